/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv32i_types::alu_ops    aluop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output rv32i_types::rv32i_word f
);
    import rv32i_types::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'd0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = rv32i_word'($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module cmp (
    input  rv32i_types::cmp_ops    cmpop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output logic                   br_en
);
    import rv32i_types::*;

    always_comb begin
        case (cmpop)
            cmp_beq:  br_en = (a == b);
            cmp_bne:  br_en = (a != b);
            cmp_blt:  br_en = ($signed(a) < $signed(b));
            cmp_bge:  br_en = ($signed(a) >= $signed(b));
            cmp_bltu: br_en = (a < b);
            cmp_bgeu: br_en = (a >= b);
            default:  br_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  rv32i_types::ctrl_word_t ctrl,
    input  rv32i_types::rv32i_word  rs1_in,
    input  rv32i_types::rv32i_word  rs2_in,
    input  rv32i_types::fwd_sel_t   fwd_rs1,
    input  rv32i_types::fwd_sel_t   fwd_rs2,
    input  rv32i_types::rv32i_word  mem_fwd_data,
    input  rv32i_types::rv32i_word  wb_fwd_data,
    output rv32i_types::rv32i_word  alu_out,
    output rv32i_types::rv32i_word  rs2_out,
    output logic                    redirect,
    output rv32i_types::rv32i_word  redirect_pc
);
    import rv32i_types::*;

    rv32i_word rs1_fwd;
    rv32i_word rs2_fwd;
    rv32i_word alumux1_out;
    rv32i_word alumux2_out;
    rv32i_word alu_f;
    logic      br_en;
    logic      is_jump;

    always_comb begin
        case (fwd_rs1)
            fwd_mem: rs1_fwd = mem_fwd_data;
            fwd_wb:  rs1_fwd = wb_fwd_data;
            default: rs1_fwd = rs1_in;
        endcase
        case (fwd_rs2)
            fwd_mem: rs2_fwd = mem_fwd_data;
            fwd_wb:  rs2_fwd = wb_fwd_data;
            default: rs2_fwd = rs2_in;
        endcase
        alumux1_out = (ctrl.alumux1_sel == mux1_pc) ? ctrl.pc : rs1_fwd;
        alumux2_out = (ctrl.alumux2_sel == mux2_imm) ? ctrl.imm : rs2_fwd;
    end

    alu u_alu (
        .aluop (ctrl.aluop),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_f)
    );

    cmp u_cmp (
        .cmpop (ctrl.cmpop),
        .a     (rs1_fwd),
        .b     (rs2_fwd),
        .br_en (br_en)
    );

    assign is_jump     = ctrl.is_jal || ctrl.is_jalr;
    assign alu_out     = is_jump ? ctrl.pc + 32'd4 : alu_f; // link value.
    assign rs2_out     = rs2_fwd;
    // alu adds pc or rs1 to imm for every control transfer.
    assign redirect_pc = {alu_f[31:1], 1'b0};
    assign redirect    = ctrl.valid && (is_jump || (ctrl.is_branch && br_en));

endmodule

`default_nettype wire

/* files.f */
rv32i_types.sv
alu.sv
cmp.sv
ex_stage.sv
id_stage.sv
mem_arbiter.sv
rv32i_core.sv
tb_rv32i_core.sv

/* id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv32i_types::instr_u     instr,
    input  rv32i_types::rv32i_word  pc,
    input  logic                    instr_valid,
    input  logic                    wb_we,
    input  logic [4:0]              wb_rd,
    input  rv32i_types::rv32i_word  wb_data,
    output rv32i_types::ctrl_word_t ctrl,
    output rv32i_types::rv32i_word  rs1_data,
    output rv32i_types::rv32i_word  rs2_data
);
    import rv32i_types::*;

    rv32i_word regs [32];

    function automatic alu_ops alu_dec(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl             = '0;
        ctrl.pc          = pc;
        ctrl.rd          = instr.r.rd;
        ctrl.aluop       = alu_add;
        ctrl.cmpop       = cmp_beq;
        ctrl.alumux1_sel = mux1_rs1;
        ctrl.alumux2_sel = mux2_imm;
        ctrl.valid       = instr_valid;
        case (instr.r.opcode)
            OP_LUI: begin
                ctrl.imm    = {instr.u.imm, 12'h000}; // rs1 stays x0.
                ctrl.reg_we = 1'b1;
            end
            OP_AUIPC: begin
                ctrl.imm         = {instr.u.imm, 12'h000};
                ctrl.alumux1_sel = mux1_pc;
                ctrl.reg_we      = 1'b1;
            end
            OP_JAL: begin
                ctrl.imm = {{12{instr.u.imm[19]}}, instr.u.imm[7:0], instr.u.imm[8],
                            instr.u.imm[18:9], 1'b0};
                ctrl.alumux1_sel = mux1_pc;
                ctrl.reg_we      = 1'b1;
                ctrl.is_jal      = 1'b1;
            end
            OP_JALR: begin
                ctrl.imm     = {{20{instr.i.imm[11]}}, instr.i.imm};
                ctrl.rs1     = instr.r.rs1;
                ctrl.reg_we  = 1'b1;
                ctrl.is_jalr = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                            instr.b.imm4_1, 1'b0};
                ctrl.rs1         = instr.r.rs1;
                ctrl.rs2         = instr.r.rs2;
                ctrl.cmpop       = cmp_ops'(instr.r.funct3);
                ctrl.alumux1_sel = mux1_pc;
                ctrl.is_branch   = 1'b1;
            end
            OP_LOAD: begin
                ctrl.imm    = {{20{instr.i.imm[11]}}, instr.i.imm};
                ctrl.rs1    = instr.r.rs1;
                ctrl.reg_we = 1'b1;
                ctrl.mem_rd = 1'b1;
            end
            OP_STORE: begin
                ctrl.imm    = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                ctrl.rs1    = instr.r.rs1;
                ctrl.rs2    = instr.r.rs2;
                ctrl.mem_wr = 1'b1;
            end
            OP_IMM: begin
                ctrl.imm    = {{20{instr.i.imm[11]}}, instr.i.imm};
                ctrl.rs1    = instr.r.rs1;
                ctrl.reg_we = 1'b1;
                ctrl.aluop  = alu_dec(instr.r.funct3,
                                      (instr.r.funct3 == 3'b101) && instr.r.funct7[5]);
            end
            OP_REG: begin
                ctrl.rs1         = instr.r.rs1;
                ctrl.rs2         = instr.r.rs2;
                ctrl.alumux2_sel = mux2_rs2;
                ctrl.reg_we      = 1'b1;
                ctrl.aluop       = alu_dec(instr.r.funct3, instr.r.funct7[5]);
            end
            default: ctrl.valid = 1'b0;
        endcase
        if (!ctrl.valid) begin
            ctrl.reg_we    = 1'b0;
            ctrl.mem_rd    = 1'b0;
            ctrl.mem_wr    = 1'b0;
            ctrl.is_branch = 1'b0;
            ctrl.is_jal    = 1'b0;
            ctrl.is_jalr   = 1'b0;
        end
    end

    // read ports see a write landing this cycle.
    always_comb begin
        rs1_data = regs[ctrl.rs1];
        rs2_data = regs[ctrl.rs2];
        if (ctrl.rs1 == 5'd0)
            rs1_data = '0;
        else if (wb_we && wb_rd == ctrl.rs1)
            rs1_data = wb_data;
        if (ctrl.rs2 == 5'd0)
            rs2_data = '0;
        else if (wb_we && wb_rd == ctrl.rs2)
            rs2_data = wb_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  if_req_valid,
    input  rv32i_types::mem_req_t if_req,
    output logic                  if_req_ready,
    output logic                  if_rsp_valid,
    input  logic                  dm_req_valid,
    input  rv32i_types::mem_req_t dm_req,
    output logic                  dm_req_ready,
    output logic                  dm_rsp_valid,
    output rv32i_types::mem_rsp_t rsp,
    output logic                  mem_req_valid,
    output rv32i_types::mem_req_t mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  rv32i_types::mem_rsp_t mem_rsp
);
    import rv32i_types::*;

    logic busy;     // read outstanding.
    logic owner_dm; // the read belongs to the data port.
    logic grant_dm;
    logic grant_if;

    assign grant_dm = !busy && dm_req_valid;
    assign grant_if = !busy && !dm_req_valid && if_req_valid;

    assign mem_req_valid = grant_dm || grant_if;
    assign mem_req       = grant_dm ? dm_req : if_req;
    assign dm_req_ready  = grant_dm && mem_req_ready;
    assign if_req_ready  = grant_if && mem_req_ready;

    assign rsp          = mem_rsp;
    assign dm_rsp_valid = busy && owner_dm && mem_rsp_valid;
    assign if_rsp_valid = busy && !owner_dm && mem_rsp_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            owner_dm <= 1'b0;
        end else if (busy) begin
            if (mem_rsp_valid)
                busy <= 1'b0;
        end else if (mem_req_valid && mem_req_ready && !mem_req.we) begin
            busy     <= 1'b1;
            owner_dm <= grant_dm;
        end
    end

endmodule

`default_nettype wire

/* rv32i_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  mem_req_valid,
    output rv32i_types::mem_req_t mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  rv32i_types::mem_rsp_t mem_rsp
);
    import rv32i_types::*;

    rv32i_word  pc;
    logic       fetch_en;
    logic       if_pending;
    logic       if_buf_valid;
    rv32i_word  if_buf;
    rv32i_word  if_instr;
    logic       if_req_valid;
    mem_req_t   if_req;
    logic       if_req_ready;
    logic       if_rsp_valid;
    logic       dm_req_valid;
    mem_req_t   dm_req;
    logic       dm_req_ready;
    logic       dm_rsp_valid;
    mem_rsp_t   rsp;
    logic       dm_pending;
    logic       dm_done;
    logic       dm_finish;
    rv32i_word  ld_data;
    rv32i_word  ld_word;
    logic       stall;
    logic       load_use;
    logic       if_take;
    logic       if_id_valid;
    instr_u     if_id_instr;
    rv32i_word  if_id_pc;
    ctrl_word_t id_ctrl;
    rv32i_word  id_rs1;
    rv32i_word  id_rs2;
    ctrl_word_t id_ex_ctrl;
    rv32i_word  id_ex_rs1;
    rv32i_word  id_ex_rs2;
    fwd_sel_t   fwd_rs1;
    fwd_sel_t   fwd_rs2;
    rv32i_word  ex_alu;
    rv32i_word  ex_rs2;
    logic       redirect;
    rv32i_word  redirect_pc;
    ctrl_word_t ex_mem_ctrl;
    rv32i_word  ex_mem_alu;
    rv32i_word  ex_mem_rs2;
    ctrl_word_t mem_wb_ctrl;
    rv32i_word  mem_wb_data;

    // mem stage wins over wb, x0 never forwards.
    function automatic fwd_sel_t fwd_pick(input logic [4:0] rs, input ctrl_word_t mem_c,
                                          input ctrl_word_t wb_c);
        if (rs == 5'd0)
            return fwd_none;
        if (mem_c.reg_we && mem_c.rd == rs)
            return fwd_mem;
        if (wb_c.reg_we && wb_c.rd == rs)
            return fwd_wb;
        return fwd_none;
    endfunction

    assign if_req_valid = fetch_en && !if_pending && !if_buf_valid;
    assign if_req       = '{addr: pc, wdata: '0, we: 1'b0};
    assign if_instr     = if_buf_valid ? if_buf : rsp.rdata;

    assign dm_req_valid = (ex_mem_ctrl.mem_rd || ex_mem_ctrl.mem_wr) && !dm_pending && !dm_done;
    assign dm_req       = '{addr: ex_mem_alu, wdata: ex_mem_rs2, we: ex_mem_ctrl.mem_wr};
    assign dm_finish    = (dm_req_valid && dm_req_ready && ex_mem_ctrl.mem_wr) || dm_rsp_valid;
    assign ld_word      = dm_done ? ld_data : rsp.rdata;

    assign load_use = id_ctrl.valid && id_ex_ctrl.mem_rd && (id_ex_ctrl.rd != 5'd0) &&
                      ((id_ex_ctrl.rd == id_ctrl.rs1) || (id_ex_ctrl.rd == id_ctrl.rs2));
    assign stall    = !(if_buf_valid || if_rsp_valid) ||
                      ((ex_mem_ctrl.mem_rd || ex_mem_ctrl.mem_wr) && !dm_done && !dm_finish);
    assign if_take  = !stall && (redirect || !load_use);

    assign fwd_rs1 = fwd_pick(id_ex_ctrl.rs1, ex_mem_ctrl, mem_wb_ctrl);
    assign fwd_rs2 = fwd_pick(id_ex_ctrl.rs2, ex_mem_ctrl, mem_wb_ctrl);

    mem_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_req_valid  (if_req_valid),
        .if_req        (if_req),
        .if_req_ready  (if_req_ready),
        .if_rsp_valid  (if_rsp_valid),
        .dm_req_valid  (dm_req_valid),
        .dm_req        (dm_req),
        .dm_req_ready  (dm_req_ready),
        .dm_rsp_valid  (dm_rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    id_stage u_id (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (if_id_instr),
        .pc          (if_id_pc),
        .instr_valid (if_id_valid),
        .wb_we       (mem_wb_ctrl.reg_we),
        .wb_rd       (mem_wb_ctrl.rd),
        .wb_data     (mem_wb_data),
        .ctrl        (id_ctrl),
        .rs1_data    (id_rs1),
        .rs2_data    (id_rs2)
    );

    ex_stage u_ex (
        .ctrl         (id_ex_ctrl),
        .rs1_in       (id_ex_rs1),
        .rs2_in       (id_ex_rs2),
        .fwd_rs1      (fwd_rs1),
        .fwd_rs2      (fwd_rs2),
        .mem_fwd_data (ex_mem_alu),
        .wb_fwd_data  (mem_wb_data),
        .alu_out      (ex_alu),
        .rs2_out      (ex_rs2),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= RESET_PC;
            fetch_en     <= 1'b0;
            if_pending   <= 1'b0;
            if_buf_valid <= 1'b0;
            dm_pending   <= 1'b0;
            dm_done      <= 1'b0;
            if_id_valid  <= 1'b0;
            id_ex_ctrl   <= '0;
            ex_mem_ctrl  <= '0;
            mem_wb_ctrl  <= '0;
        end else begin
            fetch_en <= 1'b1; // first fetch one cycle after reset.
            if (if_req_valid && if_req_ready)
                if_pending <= 1'b1;
            else if (if_rsp_valid)
                if_pending <= 1'b0;
            if (if_take) begin
                if_buf_valid <= 1'b0;
                if_id_valid  <= !redirect;
                pc           <= redirect ? redirect_pc : pc + 32'd4;
            end else if (if_rsp_valid) begin
                if_buf_valid <= 1'b1; // hold the word across the stall.
            end
            if (!stall) begin
                dm_pending <= 1'b0;
                dm_done    <= 1'b0;
            end else if (dm_finish) begin
                dm_pending <= 1'b0;
                dm_done    <= 1'b1;
            end else if (dm_req_valid && dm_req_ready) begin
                dm_pending <= 1'b1;
            end
            if (!stall) begin
                if (redirect || load_use)
                    id_ex_ctrl <= '0;
                else
                    id_ex_ctrl <= id_ctrl;
                ex_mem_ctrl <= id_ex_ctrl;
                mem_wb_ctrl <= ex_mem_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (if_rsp_valid)
            if_buf <= rsp.rdata;
        if (dm_rsp_valid)
            ld_data <= rsp.rdata;
        if (if_take) begin
            if_id_instr <= redirect ? NOP_INSTR : if_instr;
            if_id_pc    <= pc;
        end
        if (!stall) begin
            id_ex_rs1   <= id_rs1;
            id_ex_rs2   <= id_rs2;
            ex_mem_alu  <= ex_alu;
            ex_mem_rs2  <= ex_rs2;
            mem_wb_data <= ex_mem_ctrl.mem_rd ? ld_word : ex_mem_alu;
        end
    end

endmodule

`default_nettype wire

/* rv32i_types.sv */
`default_nettype none

package rv32i_types;

    typedef logic [31:0] rv32i_word;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word seen through each format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_ops;

    // encoded as the branch funct3.
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_ops;

    typedef enum logic {mux1_rs1, mux1_pc} alumux1_sel_t;
    typedef enum logic {mux2_rs2, mux2_imm} alumux2_sel_t;
    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

    typedef struct packed {
        rv32i_word    pc;
        rv32i_word    imm;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [4:0]   rd;
        alu_ops       aluop;
        cmp_ops       cmpop;
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        logic         reg_we;
        logic         mem_rd;
        logic         mem_wr;
        logic         is_branch;
        logic         is_jal;
        logic         is_jalr;
        logic         valid;
    } ctrl_word_t;

    typedef struct packed {
        rv32i_word addr;
        rv32i_word wdata;
        logic      we;
    } mem_req_t;

    typedef struct packed {
        rv32i_word rdata;
    } mem_rsp_t;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam rv32i_word NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0.
    localparam rv32i_word RESET_PC  = 32'h0000_0000;

endpackage

`default_nettype wire

/* tb_rv32i_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_core;
    import rv32i_types::*;

    logic        clk;
    logic        rst_n;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;

    logic [31:0] mem [256];
    logic [31:0] lfsr;
    int          prog_len;
    int          errors;
    int          store_count;
    string       exp_name [64];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    int          n_exp;

    logic        took;
    mem_req_t    req;
    int          ready_wait;
    int          rsp_wait;
    logic        rsp_busy;
    logic [31:0] rsp_data;

    rv32i_core uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken.
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] itype(input int op, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] stype(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2,
                                          input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input int op, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] jtype(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_store(input string name, input logic [31:0] addr,
                                input logic [31:0] data);
        exp_name[n_exp] = name;
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_program();
        emit(itype(7'h13, 0, 10, 0, 32'h200)); // x10 = store base.
        emit(itype(7'h13, 0, 1, 0, 100));
        emit(utype(7'h37, 2, 20'h12345));
        emit(utype(7'h17, 3, 20'h00001)); // auipc at 0x0c.
        emit(stype(1, 10, 0));
        emit(stype(2, 10, 4));
        emit(stype(3, 10, 8));
        emit(itype(7'h13, 0, 4, 0, -7));
        emit(rtype(7'h20, 0, 5, 1, 4)); // sub with x4 from the mem stage.
        emit(stype(5, 10, 12));
        emit(itype(7'h13, 5, 6, 4, 32'h401)); // srai by 1.
        emit(itype(7'h13, 5, 7, 4, 28));
        emit(itype(7'h13, 1, 8, 1, 4));
        emit(stype(6, 10, 16));
        emit(stype(7, 10, 20));
        emit(stype(8, 10, 24));
        emit(rtype(7'h00, 2, 9, 4, 1));
        emit(rtype(7'h00, 3, 11, 4, 1));
        emit(rtype(7'h00, 4, 12, 2, 1));
        emit(rtype(7'h00, 6, 13, 9, 12));
        emit(rtype(7'h00, 7, 14, 12, 4));
        emit(stype(9, 10, 28));
        emit(stype(11, 10, 32));
        emit(stype(13, 10, 36));
        emit(stype(14, 10, 40));
        emit(itype(7'h13, 0, 15, 0, 3));
        emit(rtype(7'h00, 0, 15, 15, 15)); // back to back chain.
        emit(rtype(7'h00, 0, 15, 15, 15));
        emit(itype(7'h13, 0, 16, 15, 1));
        emit(rtype(7'h00, 0, 17, 15, 16)); // x15 at distance two.
        emit(rtype(7'h00, 1, 18, 17, 15)); // x15 at distance three.
        emit(stype(18, 10, 44));
        emit(stype(17, 10, 48));
        emit(itype(7'h03, 2, 19, 10, 32'h100)); // lw from 0x300.
        emit(rtype(7'h00, 0, 20, 19, 1));
        emit(stype(20, 10, 52));
        emit(itype(7'h03, 2, 21, 10, 4));
        emit(stype(21, 10, 56)); // load feeds store data.
        emit(btype(0, 1, 1, 8)); // beq taken.
        emit(stype(1, 10, 60));
        emit(btype(1, 1, 1, 8)); // bne not taken.
        emit(itype(7'h13, 0, 22, 0, 55));
        emit(btype(4, 4, 1, 8)); // blt taken.
        emit(itype(7'h13, 0, 22, 0, 99));
        emit(btype(7, 1, 4, 8)); // bgeu not taken.
        emit(stype(22, 10, 60));
        emit(jtype(23, 12)); // jal at 0xb8.
        emit(itype(7'h13, 0, 22, 0, 1));
        emit(itype(7'h13, 0, 22, 0, 2));
        emit(stype(23, 10, 64));
        emit(utype(7'h17, 24, 0)); // x24 = 0xc8.
        emit(itype(7'h67, 0, 25, 24, 16)); // jalr at 0xcc.
        emit(stype(24, 10, 68));
        emit(itype(7'h13, 0, 22, 0, 3));
        emit(stype(25, 10, 68));
        emit(stype(22, 10, 72));
        emit(jtype(0, 0)); // park here.
    endtask

    task automatic load_expected();
        expect_store("addi", 32'h200, 32'd100);
        expect_store("lui", 32'h204, 32'h1234_5000);
        expect_store("auipc", 32'h208, 32'h0000_000c + 32'h0000_1000);
        expect_store("sub", 32'h20c, 32'd100 + 32'd7);
        expect_store("srai", 32'h210, 32'hffff_fffc);
        expect_store("srli", 32'h214, 32'hffff_fff9 >> 28);
        expect_store("slli", 32'h218, 32'd100 << 4);
        expect_store("slt", 32'h21c, 32'd1);
        expect_store("sltu", 32'h220, 32'd0);
        expect_store("or", 32'h224, (32'h1234_5000 ^ 32'd100) | 32'd1);
        expect_store("and", 32'h228, (32'h1234_5000 ^ 32'd100) & 32'hffff_fff9);
        expect_store("fwd_sll", 32'h22c, 32'd25 << 12);
        expect_store("fwd_add", 32'h230, 32'd12 + 32'd13);
        expect_store("load_use", 32'h234, fill_word(32'h300) + 32'd100);
        expect_store("load_store", 32'h238, 32'h1234_5000);
        expect_store("branch", 32'h23c, 32'd55);
        expect_store("jal_link", 32'h240, 32'd46 * 4 + 4);
        expect_store("jalr_link", 32'h244, 32'd51 * 4 + 4);
        expect_store("flushed", 32'h248, 32'd55);
    endtask

    // memory model with one outstanding read.
    initial begin
        forever begin
            @(posedge clk);
            took = mem_req_valid && mem_req_ready;
            req  = mem_req;
            #1;
            mem_rsp_valid = 1'b0;
            if (took && req.we) begin
                if (store_count < n_exp) begin
                    check_value({exp_name[store_count], " addr"}, exp_addr[store_count],
                                req.addr);
                    check_value({exp_name[store_count], " data"}, exp_data[store_count],
                                req.wdata);
                end else begin
                    $display("unexpected extra store to %h with data %h", req.addr,
                             req.wdata);
                    errors++;
                end
                store_count++;
                mem[req.addr[9:2]] = req.wdata;
            end else if (took) begin
                rsp_busy = 1'b1;
                rsp_wait = take_bits(2);
                rsp_data = mem[req.addr[9:2]];
            end
            if (took)
                ready_wait = take_bits(2);
            if (rsp_busy) begin
                if (rsp_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp.rdata = rsp_data;
                    rsp_busy      = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end
            mem_req_ready = (ready_wait == 0);
            if (ready_wait > 0)
                ready_wait--;
        end
    end

    initial begin
        int   wait_cycles;
        logic stalled;
        rst_n         = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        errors        = 0;
        store_count   = 0;
        n_exp         = 0;
        prog_len      = 0;
        ready_wait    = 0;
        rsp_wait      = 0;
        rsp_busy      = 1'b0;
        rsp_data      = '0;
        lfsr          = 32'h22f1_9a85;
        stalled       = 1'b0;
        for (int a = 0; a < 256; a++)
            mem[a] = fill_word(a * 4);
        load_program();
        load_expected();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n_exp && !stalled; i++) begin
            wait_cycles = 0;
            while (store_count <= i && wait_cycles < 2000) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (store_count <= i) begin
                $display("store stream stopped after %0d of %0d stores", store_count, n_exp);
                errors++;
                stalled = 1'b1;
            end
        end
        if (!stalled)
            repeat (200) @(posedge clk); // quiet period after the last store.
        $display("errors %0d, stores seen %0d, stores expected %0d", errors, store_count,
                 n_exp);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
